//--- rtl/video_rx_pkg.sv
`default_nettype none

package video_rx_pkg;

	////////////////////
	// Header match values
	////////////////////

	// Board 0 answers on the base address, board 1 on base plus one.
	localparam logic [31:0] dst_ip_base   = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [15:0] dst_udp_port  = 16'd12345;
	localparam logic [15:0] eth_type_ipv4 = 16'h0800;
	localparam logic [7:0]  ip_ver_ihl    = 8'h45;
	localparam logic [7:0]  ip_proto_udp  = 8'd17;

	////////////////////
	// Byte offsets
	////////////////////

	// Counted from the first preamble byte.
	localparam logic [10:0] off_eth_type  = 11'd20;
	localparam logic [10:0] off_ip_ver    = 11'd22;
	localparam logic [10:0] off_ip_proto  = 11'd31;
	localparam logic [10:0] off_ip_dst    = 11'd38;
	localparam logic [10:0] off_udp_dst   = 11'd44;
	localparam logic [10:0] off_line_lo   = 11'd50;
	localparam logic [10:0] off_line_hi   = 11'd51;
	localparam logic [10:0] off_frame_end = 11'd1111;

	////////////////////
	// Word layout
	////////////////////

	typedef logic [11:0] line_y_t;

	typedef struct packed {
		logic        spare;
		logic        x_flag;
		logic [10:0] line_y;
		logic [7:0]  data_hi;
		logic [7:0]  data_lo;
	} line_word_t;

	// Output buffer size in words.
	localparam int fifo_depth = 16;

endpackage

`default_nettype wire

//--- rtl/pixel_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pixel_byte_if;

	// One accepted payload byte per cycle at most.
	logic                  valid;
	logic [7:0]            data;

	// Line information of the current frame.
	video_rx_pkg::line_y_t line_y;
	logic                  x_flag;

	// High from the header match until the frame ends.
	logic                  frame_active;

	modport driver (
		output valid,
		output data,
		output line_y,
		output x_flag,
		output frame_active
	);

	modport sink (
		input valid,
		input data,
		input line_y,
		input x_flag,
		input frame_active
	);

endinterface

`default_nettype wire

//--- rtl/gmii_udp_filter.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_udp_filter (
	input  wire          clk125,
	input  wire          sys_rst,
	input  wire          board_id,
	input  wire [7:0]    rxd,
	input  wire          rx_dv,
	pixel_byte_if.driver pix
);

	logic [10:0] rx_count;

	// Captured header fields.
	logic [15:0] eth_type;
	logic [7:0]  ip_ver;
	logic [7:0]  ip_proto;
	logic [31:0] ip_dst;
	logic [15:0] udp_dst;

	logic [7:0]  dst_last_octet;
	logic        hdr_match;
	logic        in_payload;

	////////////////////
	// Header check
	////////////////////

	// Last destination octet selects the board.
	assign dst_last_octet = video_rx_pkg::dst_ip_base[7:0] + {7'd0, board_id};

	assign hdr_match = (eth_type == video_rx_pkg::eth_type_ipv4) &&
		(ip_ver == video_rx_pkg::ip_ver_ihl) &&
		(ip_proto == video_rx_pkg::ip_proto_udp) &&
		(ip_dst[31:8] == video_rx_pkg::dst_ip_base[31:8]) &&
		(ip_dst[7:0] == dst_last_octet) &&
		(udp_dst == video_rx_pkg::dst_udp_port);

	// Pixel bytes follow the two line bytes up to the last considered position.
	assign in_payload = (rx_count > video_rx_pkg::off_line_hi) &&
		(rx_count <= video_rx_pkg::off_frame_end);

	////////////////////
	// Byte counter and frame control
	////////////////////

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			rx_count         <= 11'd0;
			pix.valid        <= 1'b0;
			pix.frame_active <= 1'b0;
		end else if (!rx_dv) begin
			rx_count         <= 11'd0;
			pix.valid        <= 1'b0;
			pix.frame_active <= 1'b0;
		end else begin
			// Saturate so an overlong frame never wraps onto the header offsets.
			if (rx_count != 11'h7ff)
				rx_count <= rx_count + 11'd1;

			pix.valid <= pix.frame_active && in_payload;

			if (rx_count == video_rx_pkg::off_line_lo)
				pix.frame_active <= hdr_match;
			else if (rx_count == video_rx_pkg::off_frame_end)
				pix.frame_active <= 1'b0;
		end
	end

	////////////////////
	// Field capture
	////////////////////

	always_ff @(posedge clk125) begin
		if (!rx_dv) begin
			eth_type <= 16'h0;
			ip_ver   <= 8'h0;
			ip_proto <= 8'h0;
			ip_dst   <= 32'h0;
			udp_dst  <= 16'h0;
		end else begin
			case (rx_count)
				video_rx_pkg::off_eth_type:         eth_type[15:8] <= rxd;
				video_rx_pkg::off_eth_type + 11'd1: eth_type[7:0]  <= rxd;
				video_rx_pkg::off_ip_ver:           ip_ver         <= rxd;
				video_rx_pkg::off_ip_proto:         ip_proto       <= rxd;
				video_rx_pkg::off_ip_dst:           ip_dst[31:24]  <= rxd;
				video_rx_pkg::off_ip_dst + 11'd1:   ip_dst[23:16]  <= rxd;
				video_rx_pkg::off_ip_dst + 11'd2:   ip_dst[15:8]   <= rxd;
				video_rx_pkg::off_ip_dst + 11'd3:   ip_dst[7:0]    <= rxd;
				video_rx_pkg::off_udp_dst:          udp_dst[15:8]  <= rxd;
				video_rx_pkg::off_udp_dst + 11'd1:  udp_dst[7:0]   <= rxd;
				default: ;
			endcase
		end
	end

	// Line number and x flag come from payload bytes 0 and 1.
	always_ff @(posedge clk125) begin
		if (rx_dv && rx_count == video_rx_pkg::off_line_lo)
			pix.line_y[7:0] <= rxd;
		if (rx_dv && rx_count == video_rx_pkg::off_line_hi) begin
			pix.line_y[11:8] <= rxd[3:0];
			pix.x_flag       <= rxd[4];
		end
	end

	// Byte register, qualified by valid.
	always_ff @(posedge clk125) begin
		pix.data <= rxd;
	end

endmodule

`default_nettype wire

//--- rtl/yuv_word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module yuv_word_packer (
	input  wire                      clk125,
	input  wire                      sys_rst,
	pixel_byte_if.sink               pix,
	output logic                     wr_en,
	output video_rx_pkg::line_word_t wr_data
);

	// Position of the next byte within a three-byte group.
	typedef enum logic [1:0] {
		grp_first  = 2'd0,
		grp_second = 2'd1,
		grp_third  = 2'd2
	} grp_state_t;

	grp_state_t grp_state;
	logic [7:0] data_hi_q;

	////////////////////
	// Group counter
	////////////////////

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			grp_state <= grp_first;
			wr_en     <= 1'b0;
		end else if (pix.valid) begin
			case (grp_state)
				grp_first: begin
					wr_en     <= 1'b0;
					grp_state <= grp_second;
				end
				grp_second: begin
					wr_en     <= 1'b1;
					grp_state <= grp_third;
				end
				default: begin
					wr_en     <= 1'b1;
					grp_state <= grp_first;
				end
			endcase
		end else begin
			wr_en <= 1'b0;
			// A group left unfinished at frame end is dropped.
			if (!pix.frame_active)
				grp_state <= grp_first;
		end
	end

	////////////////////
	// Word assembly
	////////////////////

	always_ff @(posedge clk125) begin
		if (pix.valid) begin
			case (grp_state)
				grp_first: begin
					data_hi_q <= pix.data;
				end
				grp_second: begin
					wr_data.spare   <= 1'b0;
					wr_data.x_flag  <= pix.x_flag;
					wr_data.line_y  <= pix.line_y[10:0];
					wr_data.data_hi <= data_hi_q;
					wr_data.data_lo <= pix.data;
				end
				default: begin
					// Third byte travels alone in the low half.
					wr_data.spare   <= 1'b0;
					wr_data.x_flag  <= pix.x_flag;
					wr_data.line_y  <= pix.line_y[10:0];
					wr_data.data_hi <= 8'h00;
					wr_data.data_lo <= pix.data;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
	parameter type payload_t = video_rx_pkg::line_word_t
) (
	input  wire      clk125,
	input  wire      sys_rst,
	input  wire      wr_en,
	input  payload_t wr_data,
	output logic     rd_valid,
	input  wire      rd_ready,
	output payload_t rd_data,
	output logic     overflow
);

	localparam int addr_w = $clog2(video_rx_pkg::fifo_depth);

	payload_t mem [video_rx_pkg::fifo_depth];

	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] rd_ptr;
	logic [addr_w:0]   fill;

	logic full;
	logic rd_fire;
	logic wr_accept;

	assign full     = (fill == (addr_w + 1)'(video_rx_pkg::fifo_depth));
	assign rd_valid = (fill != '0);
	assign rd_fire  = rd_valid && rd_ready;

	// A read in the same cycle frees the slot for a write at full.
	assign wr_accept = wr_en && (!full || rd_fire);

	// Head entry is presented directly and holds until it is read.
	assign rd_data = mem[rd_ptr];

	////////////////////
	// Pointers and fill count
	////////////////////

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fill     <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_fire)
				rd_ptr <= rd_ptr + 1'b1;

			case ({wr_accept, rd_fire})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase

			overflow <= wr_en && !wr_accept;
		end
	end

	// Storage.
	always_ff @(posedge clk125) begin
		if (wr_accept)
			mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

//--- rtl/video_udp_rx.sv
`timescale 1ns/1ps
`default_nettype none

module video_udp_rx (
	input  wire         clk125,
	input  wire         sys_rst,
	input  wire         board_id,
	input  wire  [7:0]  rxd,
	input  wire         rx_dv,
	output logic        out_valid,
	input  wire         out_ready,
	output logic [28:0] out_word,
	output logic        overflow
);

	// Packed words from the packer into the buffer.
	logic                     pk_wr_en;
	video_rx_pkg::line_word_t pk_wr_data;

	pixel_byte_if pix_if ();

	////////////////////
	// Input side
	////////////////////

	gmii_udp_filter gmii_udp_filter_i (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.board_id (board_id),
		.rxd      (rxd),
		.rx_dv    (rx_dv),
		.pix      (pix_if.driver)
	);

	////////////////////
	// Packing
	////////////////////

	yuv_word_packer yuv_word_packer_i (
		.clk125  (clk125),
		.sys_rst (sys_rst),
		.pix     (pix_if.sink),
		.wr_en   (pk_wr_en),
		.wr_data (pk_wr_data)
	);

	////////////////////
	// Output buffer
	////////////////////

	word_fifo #(
		.payload_t (video_rx_pkg::line_word_t)
	) word_fifo_i (
		.clk125   (clk125),
		.sys_rst  (sys_rst),
		.wr_en    (pk_wr_en),
		.wr_data  (pk_wr_data),
		.rd_valid (out_valid),
		.rd_ready (out_ready),
		.rd_data  (out_word),
		.overflow (overflow)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk125,
	output logic sys_rst
);

	// 20 ns period.
	initial begin
		clk125 = 1'b0;
		forever #10 clk125 = ~clk125;
	end

	// Reset covers the first three rising edges and drops on a falling edge.
	initial begin
		sys_rst = 1'b1;
		repeat (3) @(posedge clk125);
		@(negedge clk125);
		sys_rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- testbench/video_udp_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_udp_rx_tb;

	localparam int num_tests   = 6;
	localparam int cycle_limit = 3000 * num_tests;
	// Pixel positions 52 to 1111 of a frame.
	localparam int max_pix = video_rx_pkg::off_frame_end - video_rx_pkg::off_line_hi;

	localparam logic [31:0] ip_base = video_rx_pkg::dst_ip_base;
	localparam logic [15:0] port    = video_rx_pkg::dst_udp_port;

	wire         clk125;
	wire         sys_rst;
	logic        board_id;
	logic [7:0]  rxd;
	logic        rx_dv;
	logic        out_ready;
	wire         out_valid;
	wire  [28:0] out_word;
	wire         overflow;

	logic [31:0] lfsr_state;
	logic [7:0]  ready_bits;
	logic [7:0]  frame_q[$];
	logic [7:0]  pix_q[$];
	logic [28:0] exp_q[$];
	logic [28:0] exp_word;
	logic [28:0] held_word;
	logic        held;
	logic [1:0]  ready_mode;
	logic        overflow_allowed;
	int          errors;
	int          words_seen;
	int          ovf_count;
	int          cycles;
	int          tests_passed;
	int          tests_failed;
	int          err_mark;
	int          seen_mark;
	int          ovf_mark;

	tb_clock_gen tb_clock_gen_i (
		.clk125  (clk125),
		.sys_rst (sys_rst)
	);

	video_udp_rx video_udp_rx_i (
		.clk125    (clk125),
		.sys_rst   (sys_rst),
		.board_id  (board_id),
		.rxd       (rxd),
		.rx_dv     (rx_dv),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_word  (out_word),
		.overflow  (overflow)
	);

	////////////////////
	// Random bits
	////////////////////

	// Galois form of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		int i;
		v = 8'h00;
		for (i = 0; i < n; i++) begin
			v = {v[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	////////////////////
	// Frame builder and model
	////////////////////

	// Pushes the low n bytes of v, most significant first.
	task automatic push_field(input logic [47:0] v, input int n);
		int i;
		for (i = n - 1; i >= 0; i--)
			frame_q.push_back(v[8*i +: 8]);
	endtask

	task automatic build_frame(input logic [15:0] ety, input logic [7:0] proto,
		input logic [31:0] dip, input logic [15:0] dport, input logic [11:0] line_y,
		input logic x_flag, input int n_pix);
		int i;
		logic [7:0] b;
		frame_q.delete();
		pix_q.delete();
		for (i = 0; i < 7; i++)
			frame_q.push_back(8'h55);
		frame_q.push_back(8'hd5);
		push_field(48'h020000000001, 6);
		push_field(48'h020000000002, 6);
		push_field({32'd0, ety}, 2);
		// IPv4 header with the checksum left at zero.
		push_field(48'h45, 1);
		push_field(48'h00, 1);
		push_field(48'(30 + n_pix), 2);
		push_field(48'h00004000, 4);
		push_field(48'h40, 1);
		push_field({40'd0, proto}, 1);
		push_field(48'h0, 2);
		push_field(48'hc0a80064, 4);
		push_field({16'd0, dip}, 4);
		// UDP header.
		push_field(48'h1388, 2);
		push_field({32'd0, dport}, 2);
		push_field(48'(10 + n_pix), 2);
		push_field(48'h0, 2);
		push_field({40'd0, line_y[7:0]}, 1);
		push_field({40'd0, 3'b000, x_flag, line_y[11:8]}, 1);
		for (i = 0; i < n_pix; i++) begin
			take_bits(8, b);
			pix_q.push_back(b);
			frame_q.push_back(b);
		end
	endtask

	// Second byte of a group pairs with the first, third byte goes out alone.
	task automatic expect_words(input logic [11:0] line_y, input logic x_flag);
		int i;
		int n;
		logic [7:0] hi;
		n = (pix_q.size() > max_pix) ? max_pix : pix_q.size();
		hi = 8'h00;
		for (i = 0; i < n; i++) begin
			case (i % 3)
				0: hi = pix_q[i];
				1: exp_q.push_back({1'b0, x_flag, line_y[10:0], hi, pix_q[i]});
				default: exp_q.push_back({1'b0, x_flag, line_y[10:0], 8'h00, pix_q[i]});
			endcase
		end
	endtask

	function automatic int words_for(input int n);
		return 2 * (n / 3) + (((n % 3) == 2) ? 1 : 0);
	endfunction

	////////////////////
	// Drive and wait
	////////////////////

	task automatic drive_frame();
		int i;
		for (i = 0; i < frame_q.size(); i++) begin
			@(negedge clk125);
			rxd   = frame_q[i];
			rx_dv = 1'b1;
		end
		@(negedge clk125);
		rx_dv = 1'b0;
		rxd   = 8'h00;
		repeat (11) @(negedge clk125);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge clk125);
		// Extra cycles let stray words show up.
		repeat (8) @(negedge clk125);
	endtask

	task automatic send_frame(input logic [15:0] ety, input logic [7:0] proto,
		input logic [31:0] dip, input logic [15:0] dport, input logic [11:0] line_y,
		input logic x_flag, input int n_pix, input logic accept);
		build_frame(ety, proto, dip, dport, line_y, x_flag, n_pix);
		if (accept)
			expect_words(line_y, x_flag);
		drive_frame();
		wait_drain();
	endtask

	// 0 holds out_ready low, 1 high, 2 random.
	task automatic set_ready_mode(input logic [1:0] m);
		@(posedge clk125);
		ready_mode = m;
	endtask

	task automatic check_value(input string what, input int got, input int want);
		assert (got == want) else begin
			errors++;
			$display("ERR t=%0t %s expected %0d actual %0d", $time, what, want, got);
		end
	endtask

	task automatic end_test(input string name, input int mark);
		if (errors == mark) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - mark);
		end
	endtask

	////////////////////
	// Output checks
	////////////////////

	a_valid_held: assert property (@(posedge clk125) disable iff (sys_rst)
		(out_valid && !out_ready) |=> out_valid)
		else begin
			errors++;
			$display("ERR t=%0t out_valid expected 1 actual 0", $time);
		end

	a_no_overflow: assert property (@(posedge clk125) disable iff (sys_rst)
		!overflow_allowed |-> !overflow)
		else begin
			errors++;
			$display("ERR t=%0t overflow expected 0 actual 1", $time);
		end

	always @(posedge clk125) begin
		if (!sys_rst) begin
			if (held) begin
				assert (out_word == held_word) else begin
					errors++;
					$display("ERR t=%0t out_word expected %h actual %h", $time,
						held_word, out_word);
				end
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("word %h arrived at t=%0t with none expected", out_word, $time);
				end else begin
					exp_word = exp_q.pop_front();
					assert (out_word == exp_word) else begin
						errors++;
						$display("ERR t=%0t out_word expected %h actual %h", $time,
							exp_word, out_word);
					end
				end
				words_seen++;
			end
			if (overflow)
				ovf_count++;
			held      = out_valid && !out_ready;
			held_word = out_word;
		end
	end

	always @(negedge clk125) begin
		case (ready_mode)
			2'd0: out_ready = 1'b0;
			2'd1: out_ready = 1'b1;
			default: begin
				// Ready three cycles out of four on average.
				take_bits(2, ready_bits);
				out_ready = (ready_bits[1:0] != 2'b00);
			end
		endcase
	end

	always @(posedge clk125) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d words never arrived", cycles,
				exp_q.size());
			$display("TESTS FAILED");
			$finish;
		end
	end

	////////////////////
	// Tests
	////////////////////

	initial begin
		board_id         = 1'b0;
		rxd              = 8'h00;
		rx_dv            = 1'b0;
		out_ready        = 1'b1;
		ready_mode       = 2'd1;
		overflow_allowed = 1'b0;
		lfsr_state       = 32'd75655;
		held             = 1'b0;
		held_word        = '0;
		errors           = 0;
		words_seen       = 0;
		ovf_count        = 0;
		cycles           = 0;
		tests_passed     = 0;
		tests_failed     = 0;
		@(negedge clk125);
		while (sys_rst)
			@(negedge clk125);

		err_mark = errors;
		repeat (40) begin
			@(negedge clk125);
			check_value("out_valid", int'(out_valid), 0);
			check_value("overflow", int'(overflow), 0);
		end
		end_test("idle after reset", err_mark);

		err_mark  = errors;
		seen_mark = words_seen;
		send_frame(16'h0800, 8'd17, ip_base, port, 12'h123, 1'b0, 30, 1'b1);
		check_value("word count", words_seen - seen_mark, 20);
		end_test("single frame", err_mark);

		err_mark  = errors;
		seen_mark = words_seen;
		send_frame(16'h86dd, 8'd17, ip_base, port, 12'h010, 1'b0, 12, 1'b0);
		send_frame(16'h0800, 8'd6, ip_base, port, 12'h010, 1'b0, 12, 1'b0);
		send_frame(16'h0800, 8'd17, ip_base, port + 16'd1, 12'h010, 1'b0, 12, 1'b0);
		send_frame(16'h0800, 8'd17, {ip_base[31:16], 8'd7, ip_base[7:0]}, port,
			12'h010, 1'b0, 12, 1'b0);
		board_id = 1'b1;
		send_frame(16'h0800, 8'd17, ip_base, port, 12'h010, 1'b0, 12, 1'b0);
		send_frame(16'h0800, 8'd17, {ip_base[31:8], ip_base[7:0] + 8'd1}, port,
			12'h011, 1'b1, 12, 1'b1);
		board_id = 1'b0;
		check_value("word count", words_seen - seen_mark, 8);
		end_test("header filter", err_mark);

		err_mark  = errors;
		seen_mark = words_seen;
		ovf_mark  = ovf_count;
		build_frame(16'h0800, 8'd17, ip_base, port, 12'h2a5, 1'b1, 300);
		expect_words(12'h2a5, 1'b1);
		set_ready_mode(2'd2);
		drive_frame();
		wait_drain();
		set_ready_mode(2'd1);
		check_value("word count", words_seen - seen_mark, 200);
		check_value("overflow pulses", ovf_count - ovf_mark, 0);
		end_test("random back-pressure", err_mark);

		err_mark  = errors;
		seen_mark = words_seen;
		ovf_mark  = ovf_count;
		set_ready_mode(2'd0);
		overflow_allowed = 1'b1;
		build_frame(16'h0800, 8'd17, ip_base, port, 12'h0ff, 1'b1, 60);
		expect_words(12'h0ff, 1'b1);
		drive_frame();
		repeat (8) @(negedge clk125);
		check_value("overflow pulses", ovf_count - ovf_mark, 24);
		// Only the first 16 words fit in the FIFO.
		while (exp_q.size() > 16)
			exp_q.delete(exp_q.size() - 1);
		set_ready_mode(2'd1);
		wait_drain();
		overflow_allowed = 1'b0;
		check_value("word count", words_seen - seen_mark, 16);
		end_test("overflow", err_mark);

		err_mark  = errors;
		seen_mark = words_seen;
		send_frame(16'h0800, 8'd17, ip_base, port, 12'h9c4, 1'b0, 29, 1'b1);
		check_value("word count", words_seen - seen_mark, words_for(29));
		seen_mark = words_seen;
		send_frame(16'h0800, 8'd17, ip_base, port, 12'h9c5, 1'b1, 1100, 1'b1);
		check_value("word count", words_seen - seen_mark, words_for(max_pix));
		end_test("frame ends", err_mark);

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
rtl/video_rx_pkg.sv
rtl/pixel_byte_if.sv
rtl/gmii_udp_filter.sv
rtl/yuv_word_packer.sv
rtl/word_fifo.sv
rtl/video_udp_rx.sv
testbench/tb_clock_gen.sv
testbench/video_udp_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compiles the design and testbench with Verilator, runs the simulation and
# exits non-zero unless the testbench reports a pass.
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module video_udp_rx_tb -f filelist.f &&
./obj_dir/Vvideo_udp_rx_tb | tee /dev/stderr | grep -q "^TESTS PASSED$" ||
{ echo "simulation did not pass"; exit 1; }
